//--- hdl/fp_ss_pkg.sv
/*
 * FP subsystem package
 * Widths, OP-FP encodings, operation codes and pipeline payload types
 */
package fp_ss_pkg;

  // ------------------------------
  // Widths and word types
  // ------------------------------
  localparam int unsigned FLEN = 32;

  typedef logic [FLEN-1:0] fp_word_t;
  typedef logic [4:0]      fp_reg_idx_t;
  typedef logic [31:0]     instr_t;

  // ------------------------------
  // OP-FP encoding fields
  // ------------------------------
  localparam logic [6:0] OPCODE_OP_FP = 7'b1010011;

  // funct7 including fmt = S
  localparam logic [6:0] F7_SGNJ_S   = 7'b0010000;
  localparam logic [6:0] F7_MINMAX_S = 7'b0010100;
  localparam logic [6:0] F7_CMP_S    = 7'b1010000;
  localparam logic [6:0] F7_MV_X_W   = 7'b1110000;

  localparam logic [2:0] F3_SGNJ  = 3'b000;
  localparam logic [2:0] F3_SGNJN = 3'b001;
  localparam logic [2:0] F3_SGNJX = 3'b010;
  localparam logic [2:0] F3_MIN   = 3'b000;
  localparam logic [2:0] F3_MAX   = 3'b001;
  localparam logic [2:0] F3_FEQ   = 3'b010;
  localparam logic [2:0] F3_FLT   = 3'b001;
  localparam logic [2:0] F3_FLE   = 3'b000;

  // Single precision constants
  localparam fp_word_t   CANON_NAN = 32'h7FC0_0000;
  localparam logic [7:0] EXP_ONES  = 8'hFF;

  // ------------------------------
  // Operation and payload types
  // ------------------------------
  typedef enum logic [2:0] {
    OP_SGNJ,
    OP_MINMAX,
    OP_CMP,
    OP_MV,
    OP_ILLEGAL
  } fp_op_e;

  // Decoded request, 75 bits
  typedef struct packed {
    fp_op_e      op;
    logic [2:0]  funct3;
    fp_reg_idx_t rd;
    fp_word_t    a;
    fp_word_t    b;
  } fp_dec_t;

  // Response, 38 bits
  typedef struct packed {
    fp_word_t    data;
    fp_reg_idx_t id;
    logic        error;
  } fp_resp_t;

endpackage

//--- hdl/fp_stage_reg.sv
/*
 * One-entry valid/ready pipeline register, generic over its payload
 */
`timescale 1ns/1ps

module fp_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or when the held item leaves this cycle
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

//--- hdl/fp_decoder.sv
/*
 * FP instruction decoder
 * Classifies OP-FP words, packs operands and rd, and registers event strobes
 */
`timescale 1ns/1ps

module fp_decoder
  import fp_ss_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  // Request side
  input  logic        req_valid_i,
  input  instr_t      req_op_i,
  input  fp_word_t    req_arga_i,
  input  fp_word_t    req_argb_i,
  output logic        req_ready_o,
  // Towards stage register 1
  output logic        dec_valid_o,
  output fp_dec_t     dec_o,
  input  logic        dec_ready_i,
  // Core event strobes
  output logic        issue_fpu_o,
  output logic        issue_core_to_fpu_o
);

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic [4:0] rs2;
  fp_op_e     op;
  logic       req_hs;

  assign opcode = req_op_i[6:0];
  assign funct3 = req_op_i[14:12];
  assign rs2    = req_op_i[24:20];
  assign funct7 = req_op_i[31:25];

  // ------------------------------
  // Instruction match
  // ------------------------------
  always_comb begin
    op = OP_ILLEGAL;
    if (opcode == OPCODE_OP_FP) begin
      case (funct7)
        F7_SGNJ_S: begin
          if (funct3 inside {F3_SGNJ, F3_SGNJN, F3_SGNJX}) op = OP_SGNJ;
        end
        F7_MINMAX_S: begin
          if (funct3 inside {F3_MIN, F3_MAX}) op = OP_MINMAX;
        end
        F7_CMP_S: begin
          if (funct3 inside {F3_FEQ, F3_FLT, F3_FLE}) op = OP_CMP;
        end
        F7_MV_X_W: begin
          // FMV.X.W has funct3 000 and no rs2
          if (funct3 == 3'b000 && rs2 == 5'd0) op = OP_MV;
        end
        default: op = OP_ILLEGAL;
      endcase
    end
  end

  always_comb begin
    dec_o.op     = op;
    dec_o.funct3 = funct3;
    dec_o.rd     = req_op_i[11:7];
    dec_o.a      = req_arga_i;
    dec_o.b      = req_argb_i;
  end

  // Handshake passes straight through to the first stage
  assign dec_valid_o = req_valid_i;
  assign req_ready_o = dec_ready_i;
  assign req_hs      = req_valid_i & dec_ready_i;

  // ------------------------------
  // Event strobes
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      issue_core_to_fpu_o <= 1'b0;
      issue_fpu_o         <= 1'b0;
    end else begin
      issue_core_to_fpu_o <= req_hs;
      // Illegal words are answered but never reach the unit
      issue_fpu_o         <= req_hs & (op != OP_ILLEGAL);
    end
  end

endmodule

//--- hdl/fp_alu.sv
/*
 * FP32 ALU
 * Sign injection, min/max, compare and raw move, all combinational
 */
`timescale 1ns/1ps

module fp_alu
  import fp_ss_pkg::*;
(
  input  fp_dec_t  dec_i,
  output fp_resp_t resp_o
);

  logic     a_sign, b_sign;
  logic     a_nan, b_nan;
  logic     both_zero;
  logic     a_lt_b;
  logic     feq, flt, fle;
  logic     cmp_bit;
  fp_word_t sgnj_res;
  fp_word_t minmax_res;

  assign a_sign = dec_i.a[FLEN-1];
  assign b_sign = dec_i.b[FLEN-1];

  assign a_nan = (dec_i.a[30:23] == EXP_ONES) && (dec_i.a[22:0] != '0);
  assign b_nan = (dec_i.b[30:23] == EXP_ONES) && (dec_i.b[22:0] != '0);

  assign both_zero = (dec_i.a[30:0] == '0) && (dec_i.b[30:0] == '0);

  // ------------------------------
  // Ordering, -0 below +0
  // ------------------------------
  always_comb begin
    if (a_sign != b_sign) begin
      a_lt_b = a_sign;
    end else if (!a_sign) begin
      a_lt_b = dec_i.a[30:0] < dec_i.b[30:0];
    end else begin
      // Both negative, larger magnitude is smaller
      a_lt_b = dec_i.a[30:0] > dec_i.b[30:0];
    end
  end

  // Compare treats the two zeros as equal
  assign feq = (dec_i.a == dec_i.b) | both_zero;
  assign flt = a_lt_b & ~both_zero;
  assign fle = flt | feq;

  always_comb begin
    case (dec_i.funct3)
      F3_FEQ:  cmp_bit = feq;
      F3_FLT:  cmp_bit = flt;
      F3_FLE:  cmp_bit = fle;
      default: cmp_bit = 1'b0;
    endcase
    if (a_nan || b_nan) cmp_bit = 1'b0;
  end

  always_comb begin
    case (dec_i.funct3)
      F3_SGNJ:  sgnj_res = {b_sign, dec_i.a[30:0]};
      F3_SGNJN: sgnj_res = {~b_sign, dec_i.a[30:0]};
      F3_SGNJX: sgnj_res = {a_sign ^ b_sign, dec_i.a[30:0]};
      default:  sgnj_res = dec_i.a;
    endcase
  end

  always_comb begin
    if (a_nan && b_nan) begin
      minmax_res = CANON_NAN;
    end else if (a_nan) begin
      minmax_res = dec_i.b;
    end else if (b_nan) begin
      minmax_res = dec_i.a;
    end else if (dec_i.funct3 == F3_MAX) begin
      minmax_res = a_lt_b ? dec_i.b : dec_i.a;
    end else begin
      minmax_res = a_lt_b ? dec_i.a : dec_i.b;
    end
  end

  // ------------------------------
  // Result select
  // ------------------------------
  always_comb begin
    resp_o.id    = dec_i.rd;
    resp_o.error = 1'b0;
    resp_o.data  = '0;
    case (dec_i.op)
      OP_SGNJ:   resp_o.data = sgnj_res;
      OP_MINMAX: resp_o.data = minmax_res;
      OP_CMP:    resp_o.data = {{(FLEN-1){1'b0}}, cmp_bit};
      OP_MV:     resp_o.data = dec_i.a;
      default:   resp_o.error = 1'b1;
    endcase
  end

endmodule

//--- hdl/fp_ss_top.sv
/*
 * FP subsystem top
 * Decoder, two-stage pipeline and ALU behind valid/ready request and response ports
 */
`timescale 1ns/1ps

module fp_ss_top
  import fp_ss_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  // Request port
  input  logic        acc_req_valid_i,
  input  instr_t      acc_req_op_i,
  input  fp_word_t    acc_req_arga_i,
  input  fp_word_t    acc_req_argb_i,
  output logic        acc_req_ready_o,
  // Response port
  output logic        acc_resp_valid_o,
  output fp_word_t    acc_resp_data_o,
  output fp_reg_idx_t acc_resp_id_o,
  output logic        acc_resp_error_o,
  input  logic        acc_resp_ready_i,
  // Core event strobes
  output logic        issue_fpu_o,
  output logic        issue_core_to_fpu_o
);

  logic     dec_valid, dec_ready;
  fp_dec_t  dec_data;
  logic     s1_valid, s1_ready;
  fp_dec_t  s1_data;
  fp_resp_t alu_resp;
  fp_resp_t resp_data;

  fp_decoder u_decoder (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .req_valid_i         (acc_req_valid_i),
    .req_op_i            (acc_req_op_i),
    .req_arga_i          (acc_req_arga_i),
    .req_argb_i          (acc_req_argb_i),
    .req_ready_o         (acc_req_ready_o),
    .dec_valid_o         (dec_valid),
    .dec_o               (dec_data),
    .dec_ready_i         (dec_ready),
    .issue_fpu_o         (issue_fpu_o),
    .issue_core_to_fpu_o (issue_core_to_fpu_o)
  );

  fp_stage_reg #(.payload_t(fp_dec_t)) u_dec_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (dec_valid),
    .in_data_i   (dec_data),
    .in_ready_o  (dec_ready),
    .out_valid_o (s1_valid),
    .out_data_o  (s1_data),
    .out_ready_i (s1_ready)
  );

  fp_alu u_alu (
    .dec_i  (s1_data),
    .resp_o (alu_resp)
  );

  // Result stage drives the response port
  fp_stage_reg #(.payload_t(fp_resp_t)) u_resp_stage (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (s1_valid),
    .in_data_i   (alu_resp),
    .in_ready_o  (s1_ready),
    .out_valid_o (acc_resp_valid_o),
    .out_data_o  (resp_data),
    .out_ready_i (acc_resp_ready_i)
  );

  assign acc_resp_data_o  = resp_data.data;
  assign acc_resp_id_o    = resp_data.id;
  assign acc_resp_error_o = resp_data.error;

endmodule

//--- sim/tb_fp_ss.sv
/*
 * Testbench for the FP subsystem top
 * Replays cases from a data file with random gaps and response back-pressure
 */
`timescale 1ns/1ps

module tb_fp_ss
  import fp_ss_pkg::*;
;

  localparam int STALL_LIMIT = 200;

  logic        clk_i;
  logic        rst_i;
  logic        acc_req_valid_i;
  instr_t      acc_req_op_i;
  fp_word_t    acc_req_arga_i;
  fp_word_t    acc_req_argb_i;
  logic        acc_req_ready_o;
  logic        acc_resp_valid_o;
  fp_word_t    acc_resp_data_o;
  fp_reg_idx_t acc_resp_id_o;
  logic        acc_resp_error_o;
  logic        acc_resp_ready_i;
  logic        issue_fpu_o;
  logic        issue_core_to_fpu_o;

  // Cases from the file
  instr_t      case_instr[$];
  fp_word_t    case_a[$];
  fp_word_t    case_b[$];
  fp_word_t    case_data[$];
  logic        case_err[$];

  // Expected responses, in acceptance order
  fp_word_t    exp_data_q[$];
  fp_reg_idx_t exp_id_q[$];
  logic        exp_err_q[$];

  logic [31:0] lfsr_q;
  int          core_cnt;
  int          fpu_cnt;

  fp_ss_top fp_ss_top_inst (
    .clk_i               (clk_i),
    .rst_i               (rst_i),
    .acc_req_valid_i     (acc_req_valid_i),
    .acc_req_op_i        (acc_req_op_i),
    .acc_req_arga_i      (acc_req_arga_i),
    .acc_req_argb_i      (acc_req_argb_i),
    .acc_req_ready_o     (acc_req_ready_o),
    .acc_resp_valid_o    (acc_resp_valid_o),
    .acc_resp_data_o     (acc_resp_data_o),
    .acc_resp_id_o       (acc_resp_id_o),
    .acc_resp_error_o    (acc_resp_error_o),
    .acc_resp_ready_i    (acc_resp_ready_i),
    .issue_fpu_o         (issue_fpu_o),
    .issue_core_to_fpu_o (issue_core_to_fpu_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bit(output logic b);
    lfsr_q = lfsr_next(lfsr_q);
    b = lfsr_q[0];
  endtask

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_data(input fp_word_t got, input fp_word_t exp, input int idx);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: response %0d data %h, expected %h", $time, idx, got, exp);
      abort_run();
    end
  endtask

  task automatic check_id(input fp_reg_idx_t got, input fp_reg_idx_t exp, input int idx);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: response %0d id %0d, expected %0d", $time, idx, got, exp);
      abort_run();
    end
  endtask

  task automatic check_error(input logic got, input logic exp, input int idx);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: response %0d error %b, expected %b", $time, idx, got, exp);
      abort_run();
    end
  endtask

  task automatic load_cases();
    int       fd;
    int       n;
    string    line;
    instr_t   w_instr;
    fp_word_t w_a, w_b, w_data;
    logic     w_err;
    fd = $fopen("sim/fp_ss_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file sim/fp_ss_cases.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // Skip comment and blank lines
      if (n > 0 && line.len() > 0 && line[0] != "#") begin
        n = $sscanf(line, "%h %h %h %h %h", w_instr, w_a, w_b, w_data, w_err);
        if (n == 5) begin
          case_instr.push_back(w_instr);
          case_a.push_back(w_a);
          case_b.push_back(w_b);
          case_data.push_back(w_data);
          case_err.push_back(w_err);
        end
      end
    end
    $fclose(fd);
    if (case_instr.size() == 0) begin
      $display("The case file holds no cases");
      abort_run();
    end
  endtask

  // Event strobe counters
  always @(posedge clk_i) begin
    if (rst_i) begin
      core_cnt <= 0;
      fpu_cnt  <= 0;
    end else begin
      if (issue_core_to_fpu_o) core_cnt <= core_cnt + 1;
      if (issue_fpu_o) fpu_cnt <= fpu_cnt + 1;
    end
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    int   n_cases;
    int   n_legal;
    int   req_idx;
    int   resp_idx;
    int   stall;
    logic req_pending;
    logic progress;
    logic go, r0, r1;

    rst_i            = 1'b1;
    acc_req_valid_i  = 1'b0;
    acc_req_op_i     = '0;
    acc_req_arga_i   = '0;
    acc_req_argb_i   = '0;
    acc_resp_ready_i = 1'b0;
    lfsr_q           = 32'h6345_bd7f;

    load_cases();
    n_cases = case_instr.size();
    n_legal = 0;
    foreach (case_err[i]) begin
      if (case_err[i] == 1'b0) n_legal++;
    end

    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    if (acc_req_ready_o !== 1'b1 || acc_resp_valid_o !== 1'b0 ||
        issue_fpu_o !== 1'b0 || issue_core_to_fpu_o !== 1'b0) begin
      $display("[FAIL] %0t ns: port state after reset is wrong", $time);
      abort_run();
    end

    req_idx     = 0;
    resp_idx    = 0;
    stall       = 0;
    req_pending = 1'b0;
    while (resp_idx < n_cases) begin
      @(negedge clk_i);
      if (!req_pending) begin
        acc_req_valid_i = 1'b0;
        if (req_idx < n_cases) begin
          random_bit(go);
          if (go) begin
            acc_req_valid_i = 1'b1;
            acc_req_op_i    = case_instr[req_idx];
            acc_req_arga_i  = case_a[req_idx];
            acc_req_argb_i  = case_b[req_idx];
            req_pending     = 1'b1;
          end
        end
      end
      // Ready high about three cycles in four
      random_bit(r0);
      random_bit(r1);
      acc_resp_ready_i = r0 | r1;

      @(posedge clk_i);
      progress = 1'b0;
      if (acc_req_valid_i && acc_req_ready_o) begin
        exp_data_q.push_back(case_data[req_idx]);
        exp_id_q.push_back(case_instr[req_idx][11:7]);
        exp_err_q.push_back(case_err[req_idx]);
        req_idx++;
        req_pending = 1'b0;
        progress    = 1'b1;
      end
      if (acc_resp_valid_o && acc_resp_ready_i) begin
        if (exp_data_q.size() == 0) begin
          $display("[FAIL] %0t ns: response with no request outstanding", $time);
          abort_run();
        end
        check_data(acc_resp_data_o, exp_data_q.pop_front(), resp_idx);
        check_id(acc_resp_id_o, exp_id_q.pop_front(), resp_idx);
        check_error(acc_resp_error_o, exp_err_q.pop_front(), resp_idx);
        resp_idx++;
        progress = 1'b1;
      end
      if (progress) begin
        stall = 0;
      end else begin
        stall++;
        if (stall > STALL_LIMIT) begin
          $display("Timeout: no request or response moved for %0d cycles", STALL_LIMIT);
          abort_run();
        end
      end
    end

    // Nothing may follow the last response
    repeat (4) begin
      @(negedge clk_i);
      acc_req_valid_i  = 1'b0;
      acc_resp_ready_i = 1'b1;
      @(posedge clk_i);
      if (acc_resp_valid_o) begin
        $display("[FAIL] %0t ns: extra response after the last case", $time);
        abort_run();
      end
    end

    if (core_cnt != n_cases) begin
      $display("[FAIL] %0t ns: %0d accept strobes, expected %0d", $time, core_cnt, n_cases);
      abort_run();
    end else if (fpu_cnt != n_legal) begin
      $display("[FAIL] %0t ns: %0d issue strobes, expected %0d", $time, fpu_cnt, n_legal);
      abort_run();
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

//--- sim/fp_ss_cases.txt
# Columns in hex: instruction word, operand a, operand b, expected data, expected error
# Response id is checked against bits 11:7 of the instruction word
203100D3 3F800000 C0000000 BF800000 0
20311153 3F800000 C0000000 3F800000 0
203121D3 BF800000 C0000000 3F800000 0
E0010253 7FC00001 12345678 7FC00001 0
283102D3 40400000 BF800000 BF800000 0
28311353 40400000 BF800000 40400000 0
283103D3 00000000 80000000 80000000 0
28311453 80000000 00000000 00000000 0
283104D3 7FC00000 C0A00000 C0A00000 0
28311553 7F800001 FFC00123 7FC00000 0
283105D3 C0000000 C0400000 C0400000 0
A0312653 80000000 00000000 00000001 0
A03116D3 80000000 00000000 00000000 0
A0310753 C0000000 3F800000 00000001 0
A03117D3 40000000 3F800000 00000000 0
A0312853 7FC00000 7FC00000 00000000 0
A03108D3 3F800000 FF800001 00000000 0
00310953 3F800000 3F800000 00000000 1
E01109D3 3F800000 00000000 00000000 1
00000013 12345678 9ABCDEF0 00000000 1
A0313A53 3F800000 3F800000 00000000 1
28311FD3 00000001 3F800000 3F800000 0

//--- compile.f
hdl/fp_ss_pkg.sv
hdl/fp_stage_reg.sv
hdl/fp_decoder.sv
hdl/fp_alu.sv
hdl/fp_ss_top.sv
sim/tb_fp_ss.sv
